//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bip_tb
RTL_TOP   ?= bip_cpu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/bip_control.sv
`default_nettype none

module bip_control import bip_mem_pkg::*, bip_isa_pkg::*; (
   input  wire logic  i_clk,
   input  wire logic  i_rst_n,
   input  bip_instr_u i_instruction,
   output bip_addr_t  o_addr_ins,
   output bip_addr_t  o_data_ins,
   output bip_sel_a_e o_sel_a,
   output bip_sel_b_e o_sel_b,
   output logic       o_op_code,
   output logic       o_wr_acc,
   output logic       o_wr,
   output logic       o_rd,
   output logic       o_halt
);

   bip_addr_t   pc_q;
   logic        run_q;
   logic        halt_q;
   bip_opcode_e opc;
   logic        hlt_fetch;

   assign opc       = i_instruction.a.opcode;
   assign hlt_fetch = run_q && (opc == OPC_HLT);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Program counter and run state
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The core idles for one cycle after reset so no strobe fires while the
   // program is still being loaded
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pc_q   <= '0;
         run_q  <= 1'b0;
         halt_q <= 1'b0;
      end else if (run_q) begin
         pc_q <= pc_q + bip_addr_t'(1);
         if (hlt_fetch) begin
            run_q  <= 1'b0;
            halt_q <= 1'b1;
         end
      end else if (!halt_q) begin
         run_q <= 1'b1;
      end
   end

   assign o_addr_ins = pc_q;
   assign o_halt     = halt_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      o_sel_a   = SEL_A_ALU;
      o_sel_b   = SEL_B_MEM;
      o_op_code = 1'b0;
      o_wr_acc  = 1'b0;
      o_wr      = 1'b0;
      o_rd      = 1'b0;
      if (run_q) begin
         case (opc)
            OPC_STO: begin
               o_wr = 1'b1;
            end
            OPC_LD: begin
               o_rd     = 1'b1;
               o_sel_a  = SEL_A_MEM;
               o_wr_acc = 1'b1;
            end
            OPC_LDI: begin
               o_sel_a  = SEL_A_IMM;
               o_wr_acc = 1'b1;
            end
            OPC_ADD: begin
               o_rd     = 1'b1;
               o_wr_acc = 1'b1;
            end
            OPC_ADDI: begin
               o_sel_b  = SEL_B_IMM;
               o_wr_acc = 1'b1;
            end
            OPC_SUB: begin
               o_rd      = 1'b1;
               o_op_code = 1'b1;
               o_wr_acc  = 1'b1;
            end
            OPC_SUBI: begin
               o_sel_b   = SEL_B_IMM;
               o_op_code = 1'b1;
               o_wr_acc  = 1'b1;
            end
            // HLT is handled by the run state, the rest are no-operations
            default: begin
            end
         endcase
      end
   end

   // The operand field serves as data address and as raw immediate
   assign o_data_ins = i_instruction.a.addr;

   a_halt_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_halt |-> !(o_wr || o_wr_acc));

endmodule

`default_nettype wire

//--- rtl/bip_cpu.sv
`default_nettype none

module bip_cpu import bip_mem_pkg::*, bip_isa_pkg::*; (
   input  wire logic i_clk,
   input  wire logic i_rst_n,
   input  wire logic i_prog_we,
   input  bip_addr_t i_prog_addr,
   input  bip_word_t i_prog_data,
   output bip_addr_t o_pc,
   output bip_word_t o_acc,
   output logic      o_halt,
   output logic      o_mem_wr,
   output bip_addr_t o_mem_addr,
   output bip_word_t o_mem_wdata
);

   bip_instr_u instr;
   bip_word_t  mem_rdata;
   bip_sel_a_e sel_a;
   bip_sel_b_e sel_b;
   logic       op_code;
   logic       wr_acc;
   logic       rd;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Core
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   bip_control u_control (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_instruction (instr),
      .o_addr_ins    (o_pc),
      .o_data_ins    (o_mem_addr),
      .o_sel_a       (sel_a),
      .o_sel_b       (sel_b),
      .o_op_code     (op_code),
      .o_wr_acc      (wr_acc),
      .o_wr          (o_mem_wr),
      .o_rd          (rd),
      .o_halt        (o_halt)
   );

   bip_datapath u_datapath (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_data_mem (mem_rdata),
      .i_data_ins (o_mem_addr),
      .i_sel_a    (sel_a),
      .i_sel_b    (sel_b),
      .i_op_code  (op_code),
      .i_wr_acc   (wr_acc),
      .o_acc      (o_acc),
      .o_data     (o_mem_wdata)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memories
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   bip_program_mem u_program_mem (
      .i_clk   (i_clk),
      .i_we    (i_prog_we),
      .i_waddr (i_prog_addr),
      .i_wdata (i_prog_data),
      .i_raddr (o_pc),
      .o_rdata (instr)
   );

   bip_data_mem u_data_mem (
      .i_clk   (i_clk),
      .i_wr    (o_mem_wr),
      .i_rd    (rd),
      .i_addr  (o_mem_addr),
      .i_wdata (o_mem_wdata),
      .o_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

//--- rtl/bip_data_mem.sv
`default_nettype none

module bip_data_mem import bip_mem_pkg::*; (
   input  wire logic i_clk,
   input  wire logic i_wr,
   input  wire logic i_rd,
   input  bip_addr_t i_addr,
   input  bip_word_t i_wdata,
   output bip_word_t o_rdata
);

   bip_word_t mem [BIP_DATA_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[i_addr] <= i_wdata;
      end
   end

   // Read data is zero unless a load is in progress
   assign o_rdata = i_rd ? mem[i_addr] : '0;

   a_rd_wr_excl: assert property (@(posedge i_clk) !(i_rd && i_wr));

endmodule

`default_nettype wire

//--- rtl/bip_datapath.sv
`default_nettype none

module bip_datapath import bip_mem_pkg::*, bip_isa_pkg::*; (
   input  wire logic  i_clk,
   input  wire logic  i_rst_n,
   input  bip_word_t  i_data_mem,
   input  bip_addr_t  i_data_ins,
   input  bip_sel_a_e i_sel_a,
   input  bip_sel_b_e i_sel_b,
   input  wire logic  i_op_code,
   input  wire logic  i_wr_acc,
   output bip_word_t  o_acc,
   output bip_word_t  o_data
);

   bip_word_t acc_q;
   bip_word_t imm_ext;
   bip_word_t alu_b;
   bip_word_t alu_out;
   bip_word_t acc_d;

   assign imm_ext = {{(BIP_WORD_W-BIP_ADDR_W){i_data_ins[BIP_ADDR_W-1]}}, i_data_ins};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Adder and subtractor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign alu_b   = (i_sel_b == SEL_B_IMM) ? imm_ext : i_data_mem;
   // Wraps modulo 2^16 in both directions
   assign alu_out = i_op_code ? (acc_q - alu_b) : (acc_q + alu_b);

   always_comb begin
      case (i_sel_a)
         SEL_A_MEM: acc_d = i_data_mem;
         SEL_A_IMM: acc_d = imm_ext;
         SEL_A_ALU: acc_d = alu_out;
         default:   acc_d = acc_q;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         acc_q <= '0;
      end else if (i_wr_acc) begin
         acc_q <= acc_d;
      end
   end

   assign o_acc  = acc_q;
   // Store data is always the accumulator
   assign o_data = acc_q;

   a_sel_a_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wr_acc |-> (i_sel_a != bip_sel_a_e'(2'd3)));

endmodule

`default_nettype wire

//--- rtl/bip_isa_pkg.sv
`default_nettype none

package bip_isa_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction encoding
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int BIP_OPC_W = 5;

   // Encodings above SUBI decode as no-operations
   typedef enum logic [BIP_OPC_W-1:0] {
      OPC_HLT  = 5'd0,
      OPC_STO  = 5'd1,
      OPC_LD   = 5'd2,
      OPC_LDI  = 5'd3,
      OPC_ADD  = 5'd4,
      OPC_ADDI = 5'd5,
      OPC_SUB  = 5'd6,
      OPC_SUBI = 5'd7
   } bip_opcode_e;

   // Operand read as a data memory address
   typedef struct packed {
      bip_opcode_e           opcode;
      bip_mem_pkg::bip_addr_t addr;
   } bip_instr_addr_t;

   // Operand read as a two's complement immediate
   typedef struct packed {
      bip_opcode_e                                opcode;
      logic signed [bip_mem_pkg::BIP_ADDR_W-1:0] imm;
   } bip_instr_imm_t;

   typedef union packed {
      bip_instr_addr_t a;
      bip_instr_imm_t  i;
   } bip_instr_u;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Datapath selects
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0] {
      SEL_A_MEM = 2'd0,
      SEL_A_IMM = 2'd1,
      SEL_A_ALU = 2'd2
   } bip_sel_a_e;

   typedef enum logic {
      SEL_B_MEM = 1'b0,
      SEL_B_IMM = 1'b1
   } bip_sel_b_e;

endpackage

`default_nettype wire

//--- rtl/bip_mem_pkg.sv
`default_nettype none

package bip_mem_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Word and address geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int BIP_WORD_W = 16;
   localparam int BIP_ADDR_W = 11;

   // Both memories cover the full 11-bit operand space
   localparam int BIP_PROG_DEPTH = 2048;
   localparam int BIP_DATA_DEPTH = 2048;

   typedef logic [BIP_WORD_W-1:0] bip_word_t;
   typedef logic [BIP_ADDR_W-1:0] bip_addr_t;

endpackage

`default_nettype wire

//--- rtl/bip_program_mem.sv
`default_nettype none

module bip_program_mem import bip_mem_pkg::*; (
   input  wire logic i_clk,
   input  wire logic i_we,
   input  bip_addr_t i_waddr,
   input  bip_word_t i_wdata,
   input  bip_addr_t i_raddr,
   output bip_word_t o_rdata
);

   bip_word_t mem [BIP_PROG_DEPTH];

   // Load port, usable while the core is held in reset
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Fetch returns the word in the same cycle
   assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

//--- src.f
rtl/bip_mem_pkg.sv
rtl/bip_isa_pkg.sv
rtl/bip_program_mem.sv
rtl/bip_data_mem.sv
rtl/bip_control.sv
rtl/bip_datapath.sv
rtl/bip_cpu.sv
verification/bip_clk_gen.sv
verification/bip_tb.sv

//--- verification/bip_clk_gen.sv
`default_nettype none

module bip_clk_gen (
   output logic o_clk
);

   // Period of 20 time units
   localparam int HALF_PERIOD = 10;

   initial begin
      o_clk = 1'b0;
      forever #HALF_PERIOD o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

//--- verification/bip_tb.sv
`default_nettype none

module bip_tb import bip_mem_pkg::*, bip_isa_pkg::*; ();

   localparam int RST_CYCLES    = 16;
   localparam int HALT_TIMEOUT  = 500;
   localparam int FREEZE_CYCLES = 10;

   logic        clk;
   logic        rst_n;
   logic        prog_we;
   bip_addr_t   prog_addr;
   bip_word_t   prog_data;
   bip_addr_t   pc;
   bip_word_t   acc;
   logic        halt;
   logic        mem_wr;
   bip_addr_t   mem_addr;
   bip_word_t   mem_wdata;

   bip_instr_u  prog [$];
   bip_addr_t   st_addr_q [$];
   bip_word_t   st_data_q [$];
   bip_addr_t   exp_st_addr [$];
   bip_word_t   exp_st_data [$];
   bip_word_t   exp_acc;
   bip_addr_t   exp_halt_pc;
   bip_word_t   model_mem [BIP_DATA_DEPTH];
   logic [15:0] lfsr;
   string       test_name;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   bip_clk_gen u_clk_gen (.o_clk(clk));

   bip_cpu i_dut (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_prog_we   (prog_we),
      .i_prog_addr (prog_addr),
      .i_prog_data (prog_data),
      .o_pc        (pc),
      .o_acc       (acc),
      .o_halt      (halt),
      .o_mem_wr    (mem_wr),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata)
   );

   // Every store strobe of the core, sampled mid-cycle
   always @(negedge clk) begin
      if (mem_wr === 1'b1) begin
         st_addr_q.push_back(mem_addr);
         st_data_q.push_back(mem_wdata);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[14:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic bip_instr_u encode(input bip_opcode_e op, input bip_addr_t operand);
      bip_instr_u w;
      w.a.opcode = op;
      w.a.addr   = operand;
      return w;
   endfunction

   task automatic check_word(input string what, input bip_word_t exp, input bip_word_t act);
      if (act !== exp) begin
         $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_addr(input string what, input bip_addr_t exp, input bip_addr_t act);
      if (act !== exp) begin
         $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic model_run();
      int         idx;
      int         imm_val;
      logic       done;
      bip_instr_u w;
      bip_word_t  imm_ext;
      idx         = 0;
      done        = 1'b0;
      exp_acc     = '0;
      exp_halt_pc = '0;
      exp_st_addr.delete();
      exp_st_data.delete();
      while (!done && idx < prog.size()) begin
         w = prog[idx];
         idx++;
         // Two's complement value, the top bit weighs minus 2^10
         imm_val = int'(w.i.imm[BIP_ADDR_W-2:0]);
         if (w.i.imm[BIP_ADDR_W-1]) begin
            imm_val = imm_val - 2 ** (BIP_ADDR_W - 1);
         end
         imm_ext = bip_word_t'(imm_val);
         case (w.a.opcode)
            OPC_HLT: begin
               done        = 1'b1;
               exp_halt_pc = bip_addr_t'(idx);
            end
            OPC_STO: begin
               model_mem[w.a.addr] = exp_acc;
               exp_st_addr.push_back(w.a.addr);
               exp_st_data.push_back(exp_acc);
            end
            OPC_LD:   exp_acc = model_mem[w.a.addr];
            OPC_LDI:  exp_acc = imm_ext;
            OPC_ADD:  exp_acc = exp_acc + model_mem[w.a.addr];
            OPC_ADDI: exp_acc = exp_acc + imm_ext;
            OPC_SUB:  exp_acc = exp_acc - model_mem[w.a.addr];
            OPC_SUBI: exp_acc = exp_acc - imm_ext;
            default: begin
            end
         endcase
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Program runner
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Loads prog while reset is held, runs it to HLT and checks everything
   task automatic run_program();
      int        cycles;
      bip_addr_t held_pc;
      bip_word_t held_acc;
      model_run();
      @(negedge clk);
      rst_n = 1'b0;
      st_addr_q.delete();
      st_data_q.delete();
      for (int i = 0; i < prog.size(); i++) begin
         prog_we   = 1'b1;
         prog_addr = bip_addr_t'(i);
         prog_data = prog[i];
         @(negedge clk);
      end
      prog_we = 1'b0;
      for (int i = prog.size(); i < RST_CYCLES; i++) begin
         @(negedge clk);
      end
      check_addr("pc in reset", '0, pc);
      check_word("acc in reset", '0, acc);
      check_bit("halt in reset", 1'b0, halt);
      check_bit("store strobe in reset", 1'b0, mem_wr);
      rst_n = 1'b1;
      @(negedge clk);
      check_addr("pc after reset", '0, pc);
      check_word("acc after reset", '0, acc);
      check_bit("halt after reset", 1'b0, halt);
      check_bit("store strobe after reset", 1'b0, mem_wr);
      cycles = 0;
      while (halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (halt !== 1'b1) begin
         $display("Timeout in %s: o_halt never rose within %0d cycles", test_name, HALT_TIMEOUT);
         test_errors++;
         return;
      end
      check_word("acc at halt", exp_acc, acc);
      check_addr("pc at halt", exp_halt_pc, pc);
      held_pc  = pc;
      held_acc = acc;
      repeat (FREEZE_CYCLES) begin
         @(negedge clk);
         check_addr("pc while halted", held_pc, pc);
         check_word("acc while halted", held_acc, acc);
         check_bit("halt while halted", 1'b1, halt);
         check_bit("store strobe while halted", 1'b0, mem_wr);
      end
      if (st_addr_q.size() != exp_st_addr.size()) begin
         $display("Fail %s: store count expected %0d actual %0d",
                  test_name, exp_st_addr.size(), st_addr_q.size());
         test_errors++;
      end
      for (int i = 0; i < st_addr_q.size() && i < exp_st_addr.size(); i++) begin
         check_addr($sformatf("store %0d address", i), exp_st_addr[i], st_addr_q[i]);
         check_word($sformatf("store %0d data", i), exp_st_data[i], st_data_q[i]);
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      prog.delete();
   endtask

   task automatic end_test();
      run_program();
      if (test_errors == 0) begin
         $display("Test %s: ok", test_name);
         tests_passed++;
      end else begin
         $display("Test %s: %0d errors", test_name, test_errors);
         tests_failed++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic test_reset();
      start_test("reset");
      prog.push_back(encode(OPC_LDI, bip_addr_t'(5)));
      prog.push_back(encode(OPC_HLT, '0));
      end_test();
   endtask

   task automatic test_imm();
      start_test("immediate");
      prog.push_back(encode(OPC_LDI, bip_addr_t'(-3)));
      prog.push_back(encode(OPC_ADDI, bip_addr_t'(1000)));
      prog.push_back(encode(OPC_SUBI, bip_addr_t'(-1024)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(20)));
      prog.push_back(encode(OPC_LDI, bip_addr_t'(5)));
      // Below zero and back over it
      prog.push_back(encode(OPC_SUBI, bip_addr_t'(10)));
      prog.push_back(encode(OPC_ADDI, bip_addr_t'(7)));
      prog.push_back(encode(OPC_SUBI, bip_addr_t'(1023)));
      prog.push_back(encode(OPC_HLT, '0));
      end_test();
   endtask

   task automatic test_store_load();
      start_test("store_load");
      prog.push_back(encode(OPC_LDI, bip_addr_t'(123)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(10)));
      prog.push_back(encode(OPC_LDI, bip_addr_t'(-77)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(2047)));
      prog.push_back(encode(OPC_LDI, '0));
      prog.push_back(encode(OPC_LD, bip_addr_t'(10)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(11)));
      prog.push_back(encode(OPC_LD, bip_addr_t'(2047)));
      prog.push_back(encode(OPC_HLT, '0));
      end_test();
   endtask

   task automatic test_mem_arith();
      start_test("memory_arith");
      prog.push_back(encode(OPC_LDI, bip_addr_t'(300)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(5)));
      prog.push_back(encode(OPC_LDI, bip_addr_t'(-50)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(6)));
      prog.push_back(encode(OPC_LDI, bip_addr_t'(1)));
      prog.push_back(encode(OPC_ADD, bip_addr_t'(5)));
      prog.push_back(encode(OPC_SUB, bip_addr_t'(6)));
      prog.push_back(encode(OPC_SUB, bip_addr_t'(5)));
      prog.push_back(encode(OPC_ADD, bip_addr_t'(6)));
      prog.push_back(encode(OPC_ADD, bip_addr_t'(6)));
      prog.push_back(encode(OPC_HLT, '0));
      end_test();
   endtask

   task automatic test_halt();
      start_test("halt");
      prog.push_back(encode(OPC_LDI, bip_addr_t'(9)));
      prog.push_back(encode(OPC_HLT, '0));
      // Never reached, a store here would show after halt
      prog.push_back(encode(OPC_LDI, bip_addr_t'(1)));
      prog.push_back(encode(OPC_STO, bip_addr_t'(3)));
      end_test();
   endtask

   task automatic test_random(input int n);
      int          sel;
      bip_opcode_e op;
      start_test($sformatf("random_%0d", n));
      for (int a = 0; a < 8; a++) begin
         prog.push_back(encode(OPC_LDI, bip_addr_t'(take_bits(BIP_ADDR_W))));
         prog.push_back(encode(OPC_STO, bip_addr_t'(a)));
      end
      for (int k = 0; k < 24; k++) begin
         sel = int'(take_bits(3)) % 7;
         op  = bip_opcode_e'(5'(sel + 1));
         if (op == OPC_LDI || op == OPC_ADDI || op == OPC_SUBI) begin
            prog.push_back(encode(op, bip_addr_t'(take_bits(BIP_ADDR_W))));
         end else begin
            prog.push_back(encode(op, bip_addr_t'(take_bits(3))));
         end
      end
      prog.push_back(encode(OPC_HLT, '0));
      end_test();
   endtask

   initial begin
      rst_n        = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      lfsr         = 16'd89;
      tests_passed = 0;
      tests_failed = 0;
      test_reset();
      test_imm();
      test_store_load();
      test_mem_arith();
      test_halt();
      for (int n = 0; n < 4; n++) begin
         test_random(n);
      end
      $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
